/* Makefile */
# Verilator simulation of the integer back end

LOG := sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing -j 0 --top-module tb_int_core -f build.f -o sim_int_core
	./obj_dir/sim_int_core | tee $(LOG)
	grep -q "^test passed$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* build.f */
core_pkg.sv
decode.sv
regfile.sv
execute.sv
writeback.sv
int_core.sv
tb_int_core.sv

/* core_pkg.sv */
// --------------------
// Shared types for the RV32I integer back end
// Opcodes, ALU and branch encodings, stage structs
// --------------------
`default_nettype none

package core_pkg;

  typedef logic [31:0] xlen_t;
  typedef logic [4:0]  raddr_t;

  // Major opcodes handled by this core
  typedef enum logic [6:0] {
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111,
    OPC_BRANCH = 7'b1100011,
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011
  } opcode_t;

  // funct3 of OP and OP-IMM
  typedef enum logic [2:0] {
    F3_ADD_SUB = 3'b000,
    F3_SLL     = 3'b001,
    F3_SLT     = 3'b010,
    F3_SLTU    = 3'b011,
    F3_XOR     = 3'b100,
    F3_SRL_SRA = 3'b101,
    F3_OR      = 3'b110,
    F3_AND     = 3'b111
  } funct3_t;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
    ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
  } alu_op_t;

  typedef enum logic [2:0] {
    BR_NONE, BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_BLTU, BR_BGEU
  } br_op_t;

  typedef enum logic [1:0] {
    SRC_A_RS1, SRC_A_PC, SRC_A_ZERO
  } src_a_t;

  typedef enum logic {
    SRC_B_RS2, SRC_B_IMM
  } src_b_t;

  typedef struct packed {
    xlen_t instr;
    xlen_t pc;
  } s_instr_t;

  typedef struct packed {
    xlen_t   pc;
    xlen_t   imm;
    raddr_t  rs1_addr;
    raddr_t  rs2_addr;
    raddr_t  rd_addr;
    logic    we_rd;
    src_a_t  src_a;
    src_b_t  src_b;
    alu_op_t alu_op;
    br_op_t  br_op;
    logic    jump;
    logic    jalr;
    logic    illegal;
  } s_id_ex_t;

  typedef struct packed {
    xlen_t  pc;
    raddr_t rd_addr;
    logic   we_rd;
    xlen_t  result;
    logic   branch_taken;
    xlen_t  target;
    logic   illegal;
  } s_retire_t;

endpackage

`default_nettype wire

/* decode.sv */
// --------------------
// Decode stage turning an RV32I word into execute controls
// --------------------
`timescale 1ns/10ps
`default_nettype none

module decode
  import core_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n_i,
  input  logic     adv_i,
  input  s_instr_t instr_i,
  input  logic     instr_valid_i,
  output s_id_ex_t id_ex_o,
  output logic     id_valid_o
);

  opcode_t  opcode;
  funct3_t  funct3;
  logic [6:0] funct7;
  logic     alt;
  xlen_t    imm_i, imm_b, imm_u, imm_j;
  s_id_ex_t dec;

  function automatic alu_op_t alu_from_f3(funct3_t f3, logic sub_sra);
    case (f3)
      F3_ADD_SUB: return sub_sra ? ALU_SUB : ALU_ADD;
      F3_SLL:     return ALU_SLL;
      F3_SLT:     return ALU_SLT;
      F3_SLTU:    return ALU_SLTU;
      F3_XOR:     return ALU_XOR;
      F3_SRL_SRA: return sub_sra ? ALU_SRA : ALU_SRL;
      F3_OR:      return ALU_OR;
      default:    return ALU_AND;
    endcase
  endfunction

  assign opcode = opcode_t'(instr_i.instr[6:0]);
  assign funct3 = funct3_t'(instr_i.instr[14:12]);
  assign funct7 = instr_i.instr[31:25];
  assign alt    = (funct7 == 7'b0100000);

  // Immediates, all sign extended from bit 31
  assign imm_i = {{20{instr_i.instr[31]}}, instr_i.instr[31:20]};
  assign imm_b = {{19{instr_i.instr[31]}}, instr_i.instr[31], instr_i.instr[7],
                  instr_i.instr[30:25], instr_i.instr[11:8], 1'b0};
  assign imm_u = {instr_i.instr[31:12], 12'b0};
  assign imm_j = {{11{instr_i.instr[31]}}, instr_i.instr[31], instr_i.instr[19:12],
                  instr_i.instr[20], instr_i.instr[30:21], 1'b0};

  always_comb begin
    dec          = '0;
    dec.pc       = instr_i.pc;
    dec.rs1_addr = instr_i.instr[19:15];
    dec.rs2_addr = instr_i.instr[24:20];
    dec.rd_addr  = instr_i.instr[11:7];
    dec.src_a    = SRC_A_RS1;
    dec.src_b    = SRC_B_RS2;
    dec.alu_op   = ALU_ADD;
    dec.br_op    = BR_NONE;
    case (opcode)
      OPC_OP: begin
        dec.we_rd   = 1'b1;
        dec.alu_op  = alu_from_f3(funct3, alt);
        dec.illegal = !((funct7 == 7'b0) ||
                        (alt && (funct3 == F3_ADD_SUB || funct3 == F3_SRL_SRA)));
      end
      OPC_OP_IMM: begin
        dec.we_rd  = 1'b1;
        dec.src_b  = SRC_B_IMM;
        dec.imm    = imm_i;
        dec.alu_op = alu_from_f3(funct3, alt && (funct3 == F3_SRL_SRA));
        // Only shifts constrain the upper immediate bits
        if (funct3 == F3_SLL) begin
          dec.illegal = (funct7 != 7'b0);
        end else if (funct3 == F3_SRL_SRA) begin
          dec.illegal = !((funct7 == 7'b0) || alt);
        end
      end
      OPC_LUI: begin
        dec.we_rd = 1'b1;
        dec.src_a = SRC_A_ZERO;
        dec.src_b = SRC_B_IMM;
        dec.imm   = imm_u;
      end
      OPC_AUIPC: begin
        dec.we_rd = 1'b1;
        dec.src_a = SRC_A_PC;
        dec.src_b = SRC_B_IMM;
        dec.imm   = imm_u;
      end
      OPC_JAL: begin
        dec.we_rd = 1'b1;
        dec.jump  = 1'b1;
        dec.imm   = imm_j;
      end
      OPC_JALR: begin
        dec.we_rd   = 1'b1;
        dec.jump    = 1'b1;
        dec.jalr    = 1'b1;
        dec.imm     = imm_i;
        dec.illegal = (funct3 != F3_ADD_SUB);
      end
      OPC_BRANCH: begin
        dec.imm = imm_b;
        case (instr_i.instr[14:12])
          3'b000:  dec.br_op = BR_BEQ;
          3'b001:  dec.br_op = BR_BNE;
          3'b100:  dec.br_op = BR_BLT;
          3'b101:  dec.br_op = BR_BGE;
          3'b110:  dec.br_op = BR_BLTU;
          3'b111:  dec.br_op = BR_BGEU;
          default: dec.illegal = 1'b1;
        endcase
      end
      default: dec.illegal = 1'b1;
    endcase
    if (dec.illegal) begin
      dec.we_rd = 1'b0;
    end
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      id_valid_o <= 1'b0;
    end else if (adv_i) begin
      id_valid_o <= instr_valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (adv_i) begin
      id_ex_o <= dec;
    end
  end

endmodule

`default_nettype wire

/* execute.sv */
// --------------------
// Execute stage with forwarding, ALU and branch resolution
// --------------------
`timescale 1ns/10ps
`default_nettype none

module execute
  import core_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n_i,
  input  logic      adv_i,
  input  s_id_ex_t  id_ex_i,
  input  logic      id_valid_i,
  output raddr_t    rs1_addr_o,
  output raddr_t    rs2_addr_o,
  input  xlen_t     rs1_data_i,
  input  xlen_t     rs2_data_i,
  output s_retire_t ex_wb_o,
  output logic      ex_valid_o
);

  logic      fwd_ok, fwd_rs1, fwd_rs2;
  xlen_t     rs1_val, rs2_val;
  xlen_t     op_a, op_b, alu_res;
  logic      br_cond;
  s_retire_t next_ex_wb;

  assign rs1_addr_o = id_ex_i.rs1_addr;
  assign rs2_addr_o = id_ex_i.rs2_addr;

  // Bypass from the instruction sitting in the execute register
  assign fwd_ok  = ex_valid_o && ex_wb_o.we_rd && !ex_wb_o.illegal && (ex_wb_o.rd_addr != '0);
  assign fwd_rs1 = fwd_ok && (ex_wb_o.rd_addr == id_ex_i.rs1_addr);
  assign fwd_rs2 = fwd_ok && (ex_wb_o.rd_addr == id_ex_i.rs2_addr);
  assign rs1_val = fwd_rs1 ? ex_wb_o.result : rs1_data_i;
  assign rs2_val = fwd_rs2 ? ex_wb_o.result : rs2_data_i;

  always_comb begin
    case (id_ex_i.src_a)
      SRC_A_RS1: op_a = rs1_val;
      SRC_A_PC:  op_a = id_ex_i.pc;
      default:   op_a = '0;
    endcase
    op_b = (id_ex_i.src_b == SRC_B_IMM) ? id_ex_i.imm : rs2_val;
  end

  always_comb begin
    case (id_ex_i.alu_op)
      ALU_ADD:  alu_res = op_a + op_b;
      ALU_SUB:  alu_res = op_a - op_b;
      ALU_SLL:  alu_res = op_a << op_b[4:0];
      ALU_SLT:  alu_res = ($signed(op_a) < $signed(op_b)) ? 32'd1 : 32'd0;
      ALU_SLTU: alu_res = (op_a < op_b) ? 32'd1 : 32'd0;
      ALU_XOR:  alu_res = op_a ^ op_b;
      ALU_SRL:  alu_res = op_a >> op_b[4:0];
      ALU_SRA:  alu_res = $signed(op_a) >>> op_b[4:0];
      ALU_OR:   alu_res = op_a | op_b;
      default:  alu_res = op_a & op_b;
    endcase
  end

  // Branch compare always sees the forwarded register values
  always_comb begin
    case (id_ex_i.br_op)
      BR_BEQ:  br_cond = (rs1_val == rs2_val);
      BR_BNE:  br_cond = (rs1_val != rs2_val);
      BR_BLT:  br_cond = ($signed(rs1_val) < $signed(rs2_val));
      BR_BGE:  br_cond = ($signed(rs1_val) >= $signed(rs2_val));
      BR_BLTU: br_cond = (rs1_val < rs2_val);
      BR_BGEU: br_cond = (rs1_val >= rs2_val);
      default: br_cond = 1'b0;
    endcase
  end

  always_comb begin
    next_ex_wb.pc           = id_ex_i.pc;
    next_ex_wb.rd_addr      = id_ex_i.rd_addr;
    next_ex_wb.we_rd        = id_ex_i.we_rd;
    next_ex_wb.illegal      = id_ex_i.illegal;
    next_ex_wb.result       = id_ex_i.jump ? (id_ex_i.pc + 32'd4) : alu_res;
    next_ex_wb.branch_taken = id_ex_i.jump || br_cond;
    if (id_ex_i.jalr) begin
      next_ex_wb.target = (rs1_val + id_ex_i.imm) & ~32'd1;
    end else begin
      next_ex_wb.target = id_ex_i.pc + id_ex_i.imm;
    end
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ex_valid_o <= 1'b0;
    end else if (adv_i) begin
      ex_valid_o <= id_valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (adv_i) begin
      ex_wb_o <= next_ex_wb;
    end
  end

endmodule

`default_nettype wire

/* int_core.sv */
// --------------------
// RV32I integer back end, decode through retire
// --------------------
`timescale 1ns/10ps
`default_nettype none

module int_core
  import core_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n_i,
  input  s_instr_t  instr_i,
  input  logic      instr_valid_i,
  output logic      instr_ready_o,
  output s_retire_t retire_o,
  output logic      retire_valid_o,
  input  logic      retire_ready_i
);

  s_id_ex_t  id_ex;
  logic      id_valid;
  s_retire_t ex_wb;
  logic      ex_valid;
  raddr_t    rs1_addr, rs2_addr;
  xlen_t     rs1_data, rs2_data;
  logic      wr_en;
  raddr_t    wr_addr;
  xlen_t     wr_data;
  logic      adv;

  assign instr_ready_o = adv;

  decode u_decode (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .adv_i         (adv),
    .instr_i       (instr_i),
    .instr_valid_i (instr_valid_i),
    .id_ex_o       (id_ex),
    .id_valid_o    (id_valid)
  );

  regfile u_regfile (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .rs1_addr_i (rs1_addr),
    .rs2_addr_i (rs2_addr),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data),
    .wr_en_i    (wr_en),
    .wr_addr_i  (wr_addr),
    .wr_data_i  (wr_data)
  );

  execute u_execute (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .adv_i      (adv),
    .id_ex_i    (id_ex),
    .id_valid_i (id_valid),
    .rs1_addr_o (rs1_addr),
    .rs2_addr_o (rs2_addr),
    .rs1_data_i (rs1_data),
    .rs2_data_i (rs2_data),
    .ex_wb_o    (ex_wb),
    .ex_valid_o (ex_valid)
  );

  writeback u_writeback (
    .ex_wb_i        (ex_wb),
    .ex_valid_i     (ex_valid),
    .retire_o       (retire_o),
    .retire_valid_o (retire_valid_o),
    .retire_ready_i (retire_ready_i),
    .adv_o          (adv),
    .wr_en_o        (wr_en),
    .wr_addr_o      (wr_addr),
    .wr_data_o      (wr_data)
  );

endmodule

`default_nettype wire

/* regfile.sv */
// --------------------
// Integer register file, x0 reads as zero
// --------------------
`timescale 1ns/10ps
`default_nettype none

module regfile
  import core_pkg::*;
(
  input  logic   clk,
  input  logic   rst_n_i,
  input  raddr_t rs1_addr_i,
  input  raddr_t rs2_addr_i,
  output xlen_t  rs1_data_o,
  output xlen_t  rs2_data_o,
  input  logic   wr_en_i,
  input  raddr_t wr_addr_i,
  input  xlen_t  wr_data_i
);

  xlen_t regs [1:31];

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en_i && (wr_addr_i != '0)) begin
      regs[wr_addr_i] <= wr_data_i;
    end
  end

  // Asynchronous read ports
  assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
  assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

endmodule

`default_nettype wire

/* tb_int_core.sv */
// --------------------
// Testbench for the RV32I integer back end
// Random instruction stream checked against a reference model
// --------------------
`timescale 1ns/10ps
`default_nettype none

module tb_int_core
  import core_pkg::*;
();

  localparam int NUM_INSTR = 2000;
  localparam int MAX_WAIT  = 100;

  logic      clk;
  logic      rst_n_i;
  s_instr_t  instr_i;
  logic      instr_valid_i;
  logic      instr_ready_o;
  s_retire_t retire_o;
  logic      retire_valid_o;
  logic      retire_ready_i;

  int        seed;
  int        retired;
  xlen_t     model_regs [0:31];
  s_instr_t  instr_q [$];
  int        acc_cycle_q [$];
  int        acc_stall_q [$];

  int_core dut0 (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .instr_i        (instr_i),
    .instr_valid_i  (instr_valid_i),
    .instr_ready_o  (instr_ready_o),
    .retire_o       (retire_o),
    .retire_valid_o (retire_valid_o),
    .retire_ready_i (retire_ready_i)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic fail_run();
    $display("test failed");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic abort_run(string why);
    $display("ERROR at %0t: %s", $time, why);
    fail_run();
  endtask

  task automatic compare_field(string name, xlen_t exp, xlen_t act);
    if (act !== exp) begin
      $display("FAILED at %0t: %s expected %h got %h", $time, name, exp, act);
      fail_run();
    end
  endtask

  // Fields that carry no meaning for this record are skipped unless full is set
  task automatic check_retire(s_retire_t act, s_retire_t exp, logic full);
    compare_field("retire_o.pc", exp.pc, act.pc);
    compare_field("retire_o.illegal", xlen_t'(exp.illegal), xlen_t'(act.illegal));
    compare_field("retire_o.we_rd", xlen_t'(exp.we_rd), xlen_t'(act.we_rd));
    if (full || exp.we_rd) begin
      compare_field("retire_o.rd_addr", xlen_t'(exp.rd_addr), xlen_t'(act.rd_addr));
      compare_field("retire_o.result", exp.result, act.result);
    end
    if (full || !exp.illegal) begin
      compare_field("retire_o.branch_taken", xlen_t'(exp.branch_taken),
                    xlen_t'(act.branch_taken));
    end
    if (full || exp.branch_taken || (!exp.we_rd && !exp.illegal)) begin
      compare_field("retire_o.target", exp.target, act.target);
    end
  endtask

  task automatic check_latency(int act, int exp);
    if (act != exp) begin
      $display("FAILED at %0t: retire latency expected %0d got %0d", $time, exp, act);
      fail_run();
    end
  endtask

  function automatic xlen_t alu_ref(logic [2:0] f3, logic alt, xlen_t a, xlen_t b);
    case (f3)
      3'b000: return alt ? a - b : a + b;
      3'b001: return a << b[4:0];
      3'b010: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'b011: return (a < b) ? 32'd1 : 32'd0;
      3'b100: return a ^ b;
      3'b101: begin
        if (alt)
          return $signed(a) >>> b[4:0];
        return a >> b[4:0];
      end
      3'b110: return a | b;
      default: return a & b;
    endcase
  endfunction

  // Sequential RV32I semantics on the model register file
  function automatic s_retire_t ref_retire(s_instr_t ins);
    s_retire_t   exp;
    logic [31:0] w;
    logic [6:0]  f7;
    logic [2:0]  f3;
    logic        writes;
    xlen_t       a, b, imm_i, imm_b, imm_j;
    w      = ins.instr;
    f3     = w[14:12];
    f7     = w[31:25];
    a      = model_regs[w[19:15]];
    b      = model_regs[w[24:20]];
    imm_i  = {{20{w[31]}}, w[31:20]};
    imm_b  = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
    imm_j  = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
    writes = 1'b1;
    exp         = '0;
    exp.pc      = ins.pc;
    exp.rd_addr = w[11:7];
    case (w[6:0])
      7'b0110011: begin
        exp.illegal = !(f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'b000 || f3 == 3'b101)));
        exp.result  = alu_ref(f3, f7[5], a, b);
      end
      7'b0010011: begin
        if (f3 == 3'b001)
          exp.illegal = (f7 != 7'h00);
        else if (f3 == 3'b101)
          exp.illegal = !(f7 == 7'h00 || f7 == 7'h20);
        exp.result = alu_ref(f3, (f3 == 3'b101) && f7[5], a, imm_i);
      end
      7'b0110111: exp.result = {w[31:12], 12'b0};
      7'b0010111: exp.result = ins.pc + {w[31:12], 12'b0};
      7'b1101111: begin
        exp.result       = ins.pc + 32'd4;
        exp.branch_taken = 1'b1;
        exp.target       = ins.pc + imm_j;
      end
      7'b1100111: begin
        exp.illegal      = (f3 != 3'b000);
        exp.result       = ins.pc + 32'd4;
        exp.branch_taken = 1'b1;
        exp.target       = (a + imm_i) & 32'hffff_fffe;
      end
      7'b1100011: begin
        writes     = 1'b0;
        exp.target = ins.pc + imm_b;
        case (f3)
          3'b000:  exp.branch_taken = (a == b);
          3'b001:  exp.branch_taken = (a != b);
          3'b100:  exp.branch_taken = ($signed(a) < $signed(b));
          3'b101:  exp.branch_taken = ($signed(a) >= $signed(b));
          3'b110:  exp.branch_taken = (a < b);
          3'b111:  exp.branch_taken = (a >= b);
          default: exp.illegal = 1'b1;
        endcase
      end
      default: exp.illegal = 1'b1;
    endcase
    exp.we_rd = writes && !exp.illegal;
    return exp;
  endfunction

  // Registers x0 to x4 only, so most instructions depend on recent ones
  function automatic logic [31:0] gen_word();
    logic [31:0] r;
    logic [6:0]  f7;
    logic [4:0]  rd, rs1, rs2;
    logic [2:0]  f3;
    int          kind;
    r    = $random(seed);
    rd   = raddr_t'($unsigned($random(seed)) % 5);
    rs1  = raddr_t'($unsigned($random(seed)) % 5);
    rs2  = raddr_t'($unsigned($random(seed)) % 5);
    f3   = 3'($random(seed));
    kind = $unsigned($random(seed)) % 12;
    case (kind)
      0, 1, 2: begin
        f7 = ((f3 == 3'b000 || f3 == 3'b101) && r[0]) ? 7'h20 : 7'h00;
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
      end
      3, 4: begin
        if (f3 == 3'b001)
          return {7'h00, r[4:0], rs1, f3, rd, 7'b0010011};
        if (f3 == 3'b101)
          return {(r[5] ? 7'h20 : 7'h00), r[4:0], rs1, f3, rd, 7'b0010011};
        return {r[11:0], rs1, f3, rd, 7'b0010011};
      end
      5: return {r[31:12], rd, 7'b0110111};
      6: return {r[31:12], rd, 7'b0010111};
      7: return {r[31:12], rd, 7'b1101111};
      8: return {r[11:0], rs1, 3'b000, rd, 7'b1100111};
      9, 10: begin
        if (f3 == 3'b010 || f3 == 3'b011)
          f3 = f3 + 3'd4;
        return {r[31:25], rs2, rs1, f3, r[11:7], 7'b1100011};
      end
      default: begin
        // Loads and M extension words are out of scope
        if (r[0])
          return {r[31:7], 7'b0000011};
        return {7'h01, rs2, rs1, f3, rd, 7'b0110011};
      end
    endcase
  endfunction

  initial begin : monitor
    s_instr_t  ins;
    s_retire_t exp;
    s_retire_t held;
    logic      held_valid;
    int        cycle, stalls, idle;
    held_valid = 1'b0;
    held       = '0;
    cycle      = 0;
    stalls     = 0;
    idle       = 0;
    retired    = 0;
    for (int i = 0; i < 32; i++) begin
      model_regs[i] = '0;
    end
    while (rst_n_i !== 1'b1) begin
      @(posedge clk);
      idle++;
      if (idle > MAX_WAIT) begin
        abort_run("reset was never released");
      end
    end
    idle = 0;
    forever begin
      @(posedge clk);
      if (instr_valid_i && instr_ready_o) begin
        instr_q.push_back(instr_i);
        acc_cycle_q.push_back(cycle);
        acc_stall_q.push_back(stalls);
      end
      // A refused record must hold until it is taken
      if (held_valid) begin
        if (!retire_valid_o) begin
          abort_run("retire_valid_o dropped before the retire was accepted");
        end
        check_retire(retire_o, held, 1'b1);
      end
      if (retire_valid_o && retire_ready_i) begin
        if (instr_q.size() == 0) begin
          abort_run("a record retired with no instruction outstanding");
        end
        ins = instr_q.pop_front();
        exp = ref_retire(ins);
        check_retire(retire_o, exp, 1'b0);
        check_latency(cycle - acc_cycle_q.pop_front(), 2 + stalls - acc_stall_q.pop_front());
        if (exp.we_rd && exp.rd_addr != 5'd0) begin
          model_regs[exp.rd_addr] = exp.result;
        end
        retired++;
        idle = 0;
      end else if (instr_q.size() != 0) begin
        idle++;
        if (idle > MAX_WAIT) begin
          abort_run("no retire while instructions were in flight");
        end
      end
      held_valid = retire_valid_o && !retire_ready_i;
      held       = retire_o;
      if (!instr_ready_o) begin
        stalls++;
      end
      cycle++;
    end
  end

  initial begin : stimulus
    int   issued, hold, waited;
    logic taken;
    seed           = 32'hcf9b_0213;
    rst_n_i        = 1'b0;
    instr_i        = '0;
    instr_valid_i  = 1'b0;
    retire_ready_i = 1'b1;
    issued         = 0;
    hold           = 0;
    taken          = 1'b0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n_i = 1'b1;
    @(negedge clk);
    if (!instr_ready_o || retire_valid_o) begin
      abort_run("handshake outputs wrong after reset");
    end
    while (issued < NUM_INSTR) begin
      @(negedge clk);
      // No back-pressure for the first stretch of the run
      retire_ready_i = (issued < 200) || (($unsigned($random(seed)) % 4) != 0);
      if (taken) begin
        instr_valid_i = 1'b0;
        taken         = 1'b0;
      end
      if (!instr_valid_i && (($unsigned($random(seed)) % 4) != 0)) begin
        instr_i.instr = gen_word();
        instr_i.pc    = xlen_t'($random(seed)) & 32'hffff_fffc;
        instr_valid_i = 1'b1;
        hold          = 0;
      end
      @(posedge clk);
      if (instr_valid_i && instr_ready_o) begin
        issued++;
        taken = 1'b1;
      end else if (instr_valid_i) begin
        hold++;
        if (hold > MAX_WAIT) begin
          abort_run("instruction was not accepted in time");
        end
      end
    end
    @(negedge clk);
    instr_valid_i  = 1'b0;
    retire_ready_i = 1'b1;
    waited         = 0;
    while (retired < NUM_INSTR) begin
      @(negedge clk);
      waited++;
      if (waited > MAX_WAIT) begin
        abort_run("last instructions did not retire");
      end
    end
    if (instr_q.size() == 0 && !retire_valid_o) begin
      $display("test passed");
      $finish;
    end else begin
      abort_run("a record was still offered after the last instruction retired");
    end
  end

endmodule

`default_nettype wire

/* writeback.sv */
// --------------------
// Retire stage, drives the register write and pipeline advance
// --------------------
`timescale 1ns/10ps
`default_nettype none

module writeback
  import core_pkg::*;
(
  input  s_retire_t ex_wb_i,
  input  logic      ex_valid_i,
  output s_retire_t retire_o,
  output logic      retire_valid_o,
  input  logic      retire_ready_i,
  output logic      adv_o,
  output logic      wr_en_o,
  output raddr_t    wr_addr_o,
  output xlen_t     wr_data_o
);

  logic retire_fire;

  assign retire_o       = ex_wb_i;
  assign retire_valid_o = ex_valid_i;
  assign retire_fire    = ex_valid_i && retire_ready_i;

  // Whole pipeline holds while a retire is pending and refused
  assign adv_o = !(ex_valid_i && !retire_ready_i);

  assign wr_en_o   = retire_fire && ex_wb_i.we_rd && !ex_wb_i.illegal &&
                     (ex_wb_i.rd_addr != '0);
  assign wr_addr_o = ex_wb_i.rd_addr;
  assign wr_data_o = ex_wb_i.result;

endmodule

`default_nettype wire
